//--- Makefile
# Verilator build and run for the I/O subsystem testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = io_subsystem_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = No errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/bitbang_uart_port.sv
`timescale 1ns/1ps
`default_nettype none

module bitbang_uart_port
   import io_pkg::*;
(
   input  wire       CLK_I,
   input  wire       rst,
   input  wire       uart_stb,
   input  wire       we,
   input  io_wdata_u wdata,
   output logic      rx_sample,
   output logic      tx,
   input  wire       rx
);

   logic tx_write;      // Write strobe for this slot

   assign tx_write = uart_stb & we;

   // Software does all framing, one bit per write
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         rx_sample <= 1'b1;                 // Line idles high
         tx        <= 1'b1;                 // UART idle level
      end else begin
         rx_sample <= rx;                   // Sampled every cycle, read or not
         if (tx_write) begin
            tx <= wdata.uart_view.tx;       // Bit 0 only
         end
      end
   end

   // Reads need no logic here
   // io_bus_return places rx_sample on the read data

endmodule

`default_nettype wire

//--- logic/io_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module io_addr_decode
   import io_pkg::*;
(
   input  wire        CLK_I,
   input  wire        rst,
   input  wire        stb,
   input  wire [31:0] adr,
   output logic       led_stb,
   output logic       uart_stb,
   output logic       unmapped_stb
);

   logic reset_seen;    // Set once a reset has been applied
   logic live;          // Strobes allowed through
   logic in_window;     // Region bits match the I/O map
   logic any_slot;      // At least one slot bit set

   // Reset-hold guard
   // Nothing reaches the peripherals before the first reset or while it is held
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         reset_seen <= 1'b1;
      end
   end

   assign live = reset_seen & ~rst;

   // Window check against the I/O region
   assign in_window = (adr[REGION_MSB:REGION_LSB] == IO_REGION);

   // Slot bits are one-hot by convention, but both may be set
   assign any_slot = adr[LED_SLOT_BIT] | adr[UART_SLOT_BIT];

   always_comb begin
      led_stb      = stb & live & in_window & adr[LED_SLOT_BIT];
      uart_stb     = stb & live & in_window & adr[UART_SLOT_BIT];
      // Outside the window, or no slot addressed
      // Still has to be acknowledged so the master cannot hang
      unmapped_stb = stb & live & ~(in_window & any_slot);
   end

endmodule

`default_nettype wire

//--- logic/io_bus_return.sv
`timescale 1ns/1ps
`default_nettype none

module io_bus_return
   import io_pkg::*;
(
   input  wire         CLK_I,
   input  wire         rst,
   input  wire         led_stb,
   input  wire         uart_stb,
   input  wire         unmapped_stb,
   input  wire         rx_sample,
   output logic        ack,
   output logic [31:0] rdata,
   output logic        bus_err
);

   // Same-cycle acknowledge, no wait states
   // Every live strobe hits at least one of the three
   assign ack = led_stb | uart_stb | unmapped_stb;

   // Read data
   // Only the UART has anything to return
   always_comb begin
      rdata               = '0;
      rdata[RDATA_RX_BIT] = uart_stb & rx_sample;  // Zero outside UART strobes
   end

   // Sticky error for strobes nobody claimed
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         bus_err <= 1'b0;
      end else if (unmapped_stb) begin
         bus_err <= 1'b1;                          // Held until next reset
      end
   end

endmodule

`default_nettype wire

//--- logic/io_pkg.sv
`default_nettype none

package io_pkg;

   // Address map of the I/O window
   localparam logic [4:0] IO_REGION = 5'b0110_0;  // adr[31:27] inside the window
   localparam int REGION_MSB = 31;
   localparam int REGION_LSB = 27;

   // One address bit per peripheral slot
   localparam int LED_SLOT_BIT  = 2;
   localparam int UART_SLOT_BIT = 3;

   // Read data layout
   localparam int RDATA_RX_BIT = 8;                // Sampled RX level on UART reads

   // Write data word, seen differently by each peripheral
   typedef union packed {
      struct packed {
         logic        blue_src;                    // LED3 mirrors RX when set
         logic [30:4] unused;
         logic [3:0]  leds;                        // led4 .. led1
      } led_view;
      struct packed {
         logic [31:1] unused;
         logic        tx;                          // Next TX line level
      } uart_view;
   } io_wdata_u;

endpackage

`default_nettype wire

//--- logic/io_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_top
   import io_pkg::*;
(
   input  wire         CLK_I,
   input  wire         rst,
   // Master side
   input  wire         stb,
   input  wire         we,
   input  wire [3:0]   sel,
   input  wire [31:0]  adr,
   input  io_wdata_u   wdata,
   output logic [31:0] rdata,
   output logic        ack,
   output logic        bus_err,
   // Pin side
   input  wire         rx,
   output logic        tx,
   output logic        led1,
   output logic        led2,
   output logic        led3,
   output logic        led4
);

   logic led_stb;       // LED slot selected
   logic uart_stb;      // UART slot selected
   logic unmapped_stb;  // No slot claimed the strobe
   logic rx_sample;     // Registered RX level

   // Address decode
   io_addr_decode u_decode (
      .CLK_I        (CLK_I),
      .rst          (rst),
      .stb          (stb),
      .adr          (adr),
      .led_stb      (led_stb),
      .uart_stb     (uart_stb),
      .unmapped_stb (unmapped_stb)
   );

   // Peripherals
   bitbang_uart_port u_uart (
      .CLK_I     (CLK_I),
      .rst       (rst),
      .uart_stb  (uart_stb),
      .we        (we),
      .wdata     (wdata),
      .rx_sample (rx_sample),
      .tx        (tx),
      .rx        (rx)
   );

   led_port u_leds (
      .CLK_I     (CLK_I),
      .rst       (rst),
      .led_stb   (led_stb),
      .we        (we),
      .sel       (sel),
      .wdata     (wdata),
      .rx_sample (rx_sample),     // Drives LED3 when blue_src is set
      .led1      (led1),
      .led2      (led2),
      .led3      (led3),
      .led4      (led4)
   );

   // Acknowledge, read data and error back to the master
   io_bus_return u_return (
      .CLK_I        (CLK_I),
      .rst          (rst),
      .led_stb      (led_stb),
      .uart_stb     (uart_stb),
      .unmapped_stb (unmapped_stb),
      .rx_sample    (rx_sample),
      .ack          (ack),
      .rdata        (rdata),
      .bus_err      (bus_err)
   );

endmodule

`default_nettype wire

//--- logic/led_port.sv
`timescale 1ns/1ps
`default_nettype none

module led_port
   import io_pkg::*;
(
   input  wire       CLK_I,
   input  wire       rst,
   input  wire       led_stb,
   input  wire       we,
   input  wire [3:0] sel,
   input  io_wdata_u wdata,
   input  wire       rx_sample,
   output logic      led1,
   output logic      led2,
   output logic      led3,
   output logic      led4
);

   logic led_write;     // Write strobe for this slot
   logic blue_src;      // LED3 follows UART RX activity
   logic src_write;     // Top byte lane enabled

   assign led_write = led_stb & we;
   assign src_write = led_write & sel[3];  // blue_src lives in bit 31

   // Plain LEDs, written as a group
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         led1 <= 1'b0;
         led2 <= 1'b0;
         led4 <= 1'b0;
      end else if (led_write) begin
         led1 <= wdata.led_view.leds[0];
         led2 <= wdata.led_view.leds[1];
         led4 <= wdata.led_view.leds[3];
      end
   end

   // Source select for the blue LED
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         blue_src <= 1'b0;                 // Software owns LED3 after reset
      end else if (src_write) begin
         blue_src <= wdata.led_view.blue_src;
      end
   end

   // LED3 is shared between software and RX activity
   // RX mirroring wins, written bit 2 is dropped meanwhile
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         led3 <= 1'b0;
      end else if (blue_src) begin
         led3 <= ~rx_sample;               // Lit while the line is low
      end else if (led_write) begin
         led3 <= wdata.led_view.leds[2];
      end
   end

endmodule

`default_nettype wire

//--- project.f
logic/io_pkg.sv
logic/io_addr_decode.sv
logic/bitbang_uart_port.sv
logic/led_port.sv
logic/io_bus_return.sv
logic/io_subsystem_top.sv
verification/io_subsystem_properties.sv
verification/io_subsystem_tb.sv

//--- verification/io_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_properties (
   input wire CLK_I,
   input wire rst,
   input wire stb,
   input wire we,
   input wire uart_stb,
   input wire ack,
   input wire tx,
   input wire bus_err,
   input wire led1,
   input wire led2,
   input wire led3,
   input wire led4
);

   // Same-cycle acknowledge, no wait states
   ack_follows_stb: assert property (@(posedge CLK_I) disable iff (rst) ack == stb)
      else $error("ack differs from stb");

   // TX moves only through a UART write
   tx_only_on_write: assert property (@(posedge CLK_I) disable iff (rst)
      !$stable(tx) |-> $past(uart_stb && we))
      else $error("tx changed without a UART write strobe");

   // Sticky error, only reset clears it
   err_sticky: assert property (@(posedge CLK_I) disable iff (rst)
      ($past(bus_err) && !$past(rst)) |-> bus_err)
      else $error("bus_err fell outside reset");

   // LEDs dark once reset has been applied
   leds_clear_after_reset: assert property (@(posedge CLK_I)
      rst |=> ({led4, led3, led2, led1} == 4'b0000))
      else $error("LEDs not cleared by reset");

endmodule

// Attach to every instance of the top level
bind io_subsystem_top io_subsystem_properties u_props (
   .CLK_I    (CLK_I),
   .rst      (rst),
   .stb      (stb),
   .we       (we),
   .uart_stb (uart_stb),
   .ack      (ack),
   .tx       (tx),
   .bus_err  (bus_err),
   .led1     (led1),
   .led2     (led2),
   .led3     (led3),
   .led4     (led4)
);

`default_nettype wire

//--- verification/io_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_tb
   import io_pkg::*;
();

   localparam logic [31:0] LFSR_SEED   = 32'h73b5_9510;
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;   // x^32+x^22+x^2+x+1
   localparam int          ACK_TIMEOUT = 20;              // ns to wait for ack

   // Address map built from the package
   localparam logic [31:0] IO_BASE  = {IO_REGION, 27'd0};
   localparam logic [31:0] LED_ADR  = IO_BASE | (32'd1 << LED_SLOT_BIT);
   localparam logic [31:0] UART_ADR = IO_BASE | (32'd1 << UART_SLOT_BIT);
   localparam logic [31:0] BOTH_ADR = LED_ADR | UART_ADR;   // Strobes both slots

   // One table row per bus cycle
   typedef struct packed {
      logic        stb;
      logic [31:0] adr;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] wdata;
      logic [3:0]  exp_leds;     // led4..led1 after the edge
      logic        mirror;       // led3 expected from RX instead
      logic        exp_tx;
      logic [31:0] exp_rdata;    // During the strobe
      logic        rd_rx;        // RX sample expected on bit 8
      logic        exp_err;
   } step_t;

   logic        CLK_I;
   logic        rst;
   logic        stb;
   logic        we;
   logic [3:0]  sel;
   logic [31:0] adr;
   io_wdata_u   wdata;
   logic [31:0] rdata;
   logic        ack;
   logic        bus_err;
   logic        rx;
   logic        tx;
   logic        led1;
   logic        led2;
   logic        led3;
   logic        led4;

   logic [31:0] lfsr;
   logic        rx_seen;         // Model of the registered RX level
   step_t       steps[$];

   io_subsystem_top uut (
      .CLK_I   (CLK_I),
      .rst     (rst),
      .stb     (stb),
      .we      (we),
      .sel     (sel),
      .adr     (adr),
      .wdata   (wdata),
      .rdata   (rdata),
      .ack     (ack),
      .bus_err (bus_err),
      .rx      (rx),
      .tx      (tx),
      .led1    (led1),
      .led2    (led2),
      .led3    (led3),
      .led4    (led4)
   );

   initial begin
      CLK_I = 1'b0;
      forever #50 CLK_I = ~CLK_I;           // 100 ns period
   end

   // Galois form with one step per bit taken
   function automatic logic [31:0] next_lfsr(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ LFSR_TAPS;
      else
         return state >> 1;
   endfunction

   task automatic stop_with_error(input string line);
      $display("%s", line);
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_leds(input logic [3:0] got, input logic [3:0] exp, input string what);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail at %0t ns: %s is %b, expected %b",
                                   $time, what, got, exp));
      end
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                   $time, what, got, exp));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail at %0t ns: %s is %b, expected %b",
                                   $time, what, got, exp));
      end
   endtask

   // Bounded wait for the acknowledge of a strobe
   task automatic wait_for_ack();
      int n;
      for (n = 0; n < ACK_TIMEOUT; n++) begin
         #1;
         if (ack === 1'b1)
            break;
      end
      if (ack !== 1'b1) begin
         stop_with_error($sformatf("Timeout at %0t ns: no ack within %0d ns of the strobe",
                                   $time, ACK_TIMEOUT));
      end
   endtask

   // Next rising edge and then the drive point
   task automatic advance_cycle();
      @(posedge CLK_I);
      rx_seen = rst ? 1'b1 : rx;            // What the DUT just registered
      #5;
      rx   = lfsr[0];                       // New random RX level each cycle
      lfsr = next_lfsr(lfsr);
   endtask

   task automatic add_step(input logic s, input logic [31:0] a, input logic w,
                           input logic [3:0] bs, input logic [31:0] d,
                           input logic [3:0] el, input logic m, input logic et,
                           input logic [31:0] er, input logic rr, input logic ee);
      steps.push_back('{s, a, w, bs, d, el, m, et, er, rr, ee});
   endtask

   task automatic check_idle_outputs();
      #1;                                   // Reset release settles
      check_bit(ack, 1'b0, "ack after reset");
      check_bit(tx, 1'b1, "tx after reset");
      check_leds({led4, led3, led2, led1}, 4'b0000, "LEDs after reset");
      check_bit(bus_err, 1'b0, "bus_err after reset");
   endtask

   task automatic build_table();
      // stb adr we sel wdata / leds mirror tx rdata rd_rx err
      add_step(1'b0, 32'h0, 1'b0, 4'h0, 32'h0,          4'b0000, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b1, 4'hF, 32'h0000_0005, 4'b0101, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b1, 4'h1, 32'h0000_000A, 4'b1010, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b0, 4'hF, 32'hFFFF_FFFF, 4'b1010, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b1, 4'h7, 32'h8000_000F, 4'b1111, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      // Setting blue_src hands led3 to RX from the next edge on
      add_step(1'b1, LED_ADR, 1'b1, 4'h8, 32'h8000_0000, 4'b0000, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b1, 4'h1, 32'h0000_0004, 4'b0000, 1'b1, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b0, 32'h0, 1'b0, 4'h0, 32'h0,          4'b0000, 1'b1, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b0, 32'h0, 1'b0, 4'h0, 32'h0,          4'b0000, 1'b1, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b1, 4'h7, 32'h0000_000F, 4'b1011, 1'b1, 1'b1, 32'h0, 1'b0, 1'b0);
      // UART writes and reads
      add_step(1'b1, UART_ADR, 1'b1, 4'hF, 32'hFFFF_FFFE, 4'b1011, 1'b1, 1'b0, 32'h0, 1'b1, 1'b0);
      add_step(1'b1, UART_ADR, 1'b0, 4'hF, 32'h0000_0001, 4'b1011, 1'b1, 1'b0, 32'h0, 1'b1, 1'b0);
      add_step(1'b1, UART_ADR, 1'b1, 4'h1, 32'h0000_0001, 4'b1011, 1'b1, 1'b1, 32'h0, 1'b1, 1'b0);
      // Clearing blue_src leaves one mirrored edge before software owns led3 again
      add_step(1'b1, LED_ADR, 1'b1, 4'h8, 32'h0000_0004, 4'b0000, 1'b1, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, LED_ADR, 1'b1, 4'h1, 32'h0000_0004, 4'b0100, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
      add_step(1'b1, BOTH_ADR, 1'b1, 4'h1, 32'h0000_0003, 4'b0011, 1'b0, 1'b1, 32'h0, 1'b1, 1'b0);
      add_step(1'b1, BOTH_ADR, 1'b1, 4'h1, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0);
      add_step(1'b1, UART_ADR, 1'b0, 4'h0, 32'h0,        4'b0000, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0);
      // Unmapped strobes are acknowledged but ignored
      add_step(1'b1, IO_BASE, 1'b1, 4'hF, 32'hFFFF_FFFF, 4'b0000, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
      add_step(1'b1, 32'h4000_0004, 1'b1, 4'hF, 32'hFFFF_FFFF,
               4'b0000, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
      add_step(1'b1, 32'hE000_0008, 1'b1, 4'hF, 32'h0000_0001,
               4'b0000, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
      add_step(1'b1, LED_ADR, 1'b1, 4'hF, 32'h0000_0009, 4'b1001, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
      add_step(1'b0, 32'h0, 1'b0, 4'h0, 32'h0,          4'b1001, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
   endtask

   initial begin : main
      step_t       cur;
      logic [31:0] exp_rd;
      logic [3:0]  exp_leds;
      logic        rx_before;
      rst     = 1'b1;
      stb     = 1'b0;
      we      = 1'b0;
      sel     = 4'h0;
      adr     = 32'h0;
      wdata   = '0;
      rx      = 1'b1;
      lfsr    = LFSR_SEED;
      rx_seen = 1'b1;
      build_table();

      repeat (10) advance_cycle();          // Reset held for 10 edges
      rst = 1'b0;
      check_idle_outputs();

      foreach (steps[i]) begin
         cur = steps[i];
         stb   = cur.stb;
         adr   = cur.adr;
         we    = cur.we;
         sel   = cur.sel;
         wdata = cur.wdata;
         if (cur.stb) begin
            wait_for_ack();                 // Same-cycle acknowledge
         end else begin
            #1;
            check_bit(ack, 1'b0, "ack without strobe");
         end
         exp_rd = cur.exp_rdata;
         if (cur.rd_rx)
            exp_rd[RDATA_RX_BIT] = rx_seen; // Previous-cycle RX
         check_word(rdata, exp_rd, "rdata");
         rx_before = rx_seen;               // Feeds led3 at the coming edge
         advance_cycle();
         exp_leds = cur.exp_leds;
         if (cur.mirror)
            exp_leds[2] = ~rx_before;
         check_leds({led4, led3, led2, led1}, exp_leds, "LEDs");
         check_bit(tx, cur.exp_tx, "tx");
         check_bit(bus_err, cur.exp_err, "bus_err");
      end

      // Second reset clears the sticky error
      stb = 1'b0;
      we  = 1'b0;
      rst = 1'b1;
      repeat (2) advance_cycle();
      rst = 1'b0;
      check_idle_outputs();

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire
